//--- sim/l2_cache_trace.txt
# op address write_seed read_seed wb_address evict_address
# none marks a request with no write-back or no eviction
# line data repeats its 16-bit seed, unwritten memory lines use their line address as seed
# set 0: fill an empty set, reread, write hit
R 1004 0000 1000 none none
R 1010 0000 1000 none none
W 1000 a5a5 0000 none none
R 1000 0000 a5a5 none none
# set 1: fill all eight ways, the tree places them in ways 0 4 2 6 1 5 3 7
R 2020 0000 2020 none none
R 2120 0000 2120 none none
W 2220 5a5a 0000 none none
R 2320 0000 2320 none none
R 2420 0000 2420 none none
R 2520 0000 2520 none none
R 2620 0000 2620 none none
R 2720 0000 2720 none none
# touch ways 0 and 4 so the tree points at way 2
R 2024 0000 2020 none none
R 2120 0000 2120 none none
# ninth tag writes back dirty way 2, then the next miss evicts clean way 6
R 2820 0000 2820 2220 2220
R 2220 0000 5a5a none 2320
R 2220 0000 5a5a none none
R 1000 0000 a5a5 none none
# write miss over clean way 1
W 2920 c3c3 0000 none 2420
R 2920 0000 c3c3 none none

//--- list.f
source/l2_cache_pkg.sv
source/l2_way_array.sv
source/l2_plru.sv
source/l2_cache_control.sv
source/l2_cache.sv
sim/tb_clock.sv
sim/l2_cache_tb.sv

//--- Bender.yml
package:
  name: l2_cache

sources:
  - source/l2_cache_pkg.sv
  - source/l2_way_array.sv
  - source/l2_plru.sv
  - source/l2_cache_control.sv
  - source/l2_cache.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/l2_cache_tb.sv

//--- sim/l2_cache_tb.sv
module l2_cache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_wait = 200;

    logic                 clk;
    logic                 reset;
    logic                 mem_read;
    logic                 mem_write;
    l2_cache_pkg::l2_word mem_address;
    l2_cache_pkg::l2_line mem_wdata;
    logic                 mem_resp;
    l2_cache_pkg::l2_line mem_rdata;
    logic                 pmem_read;
    logic                 pmem_write;
    l2_cache_pkg::l2_word pmem_address;
    l2_cache_pkg::l2_line pmem_wdata;
    logic                 pmem_resp;
    l2_cache_pkg::l2_line pmem_rdata;
    logic                 eviction;
    l2_cache_pkg::l2_word evict_address;

    l2_cache_pkg::l2_line phys_mem [l2_cache_pkg::l2_word];     // lines written back
    logic [15:0]          last_write [l2_cache_pkg::l2_word];   // seed of the newest upstream write
    bit                   resident [l2_cache_pkg::l2_word];
    int                   checks;
    int                   errors;
    int                   timeouts;
    int                   mem_delay;                            // 0 while memory is idle
    int                   write_delay;                          // latency of the last write-back

    tb_clock clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    l2_cache #(
        .set_bits (3)
    ) DUT (.*);

    function automatic l2_cache_pkg::l2_line seed_line(input logic [15:0] seed);
        return {16{seed}};
    endfunction

    task automatic check_value(input string name, input l2_cache_pkg::l2_line expected,
                               input l2_cache_pkg::l2_line actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Fail %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    // ########################################
    // physical memory, answers after 1 to 4 cycles

    task automatic serve_memory();
        if (pmem_resp) begin
            pmem_resp <= 1'b0;
        end else if (pmem_read || pmem_write) begin
            if (mem_delay == 0) begin
                mem_delay = 1 + ($urandom % 4);
                if (pmem_write) begin
                    write_delay = mem_delay;
                end
            end
            mem_delay--;
            if (mem_delay == 0) begin
                if (pmem_write) begin
                    phys_mem[pmem_address] = pmem_wdata;
                end else if (phys_mem.exists(pmem_address)) begin
                    pmem_rdata <= phys_mem[pmem_address];
                end else begin
                    pmem_rdata <= seed_line(pmem_address);    // untouched lines
                end
                pmem_resp <= 1'b1;
            end
        end
    endtask

    // ########################################
    // one upstream request

    task automatic run_request(input int n, input logic is_write,
                               input l2_cache_pkg::l2_word addr,
                               input logic [15:0] wseed, input logic [15:0] rseed,
                               input logic has_wb, input l2_cache_pkg::l2_word wb_addr,
                               input logic has_ev, input l2_cache_pkg::l2_word ev_addr);
        l2_cache_pkg::l2_word line_addr;
        string                name;
        int                   cycles;
        int                   fetches;
        int                   write_backs;
        int                   write_cycles;
        int                   evict_cycles;
        logic                 done;

        line_addr    = {addr[15:5], 5'b0};
        name         = $sformatf("request %0d", n);
        cycles       = 0;
        fetches      = 0;
        write_backs  = 0;
        write_cycles = 0;
        evict_cycles = 0;
        done         = 1'b0;
        @(posedge clk);
        mem_read    <= !is_write;
        mem_write   <= is_write;
        mem_address <= addr;
        mem_wdata   <= seed_line(wseed);
        while (!done && cycles < max_wait) begin
            @(posedge clk);
            cycles++;
            if (eviction) begin
                evict_cycles++;
                if (has_ev) check_value({name, " evict_address"}, ev_addr, evict_address);
            end
            if (pmem_write) write_cycles++;
            if (pmem_resp && pmem_read) begin
                fetches++;
                check_value({name, " fetch address"}, line_addr, pmem_address);
            end
            if (pmem_resp && pmem_write) begin
                write_backs++;
                if (has_wb) begin
                    check_value({name, " write-back address"}, wb_addr, pmem_address);
                    check_value({name, " write-back data"}, seed_line(last_write[wb_addr]),
                                pmem_wdata);
                end
            end
            if (mem_resp) begin
                done = 1'b1;
                mem_read  <= 1'b0;
                mem_write <= 1'b0;
                if (!is_write) check_value({name, " rdata"}, seed_line(rseed), mem_rdata);
            end
            serve_memory();
        end
        if (!done) begin
            timeouts++;
            $display("timeout, request %0d got no mem_resp within %0d cycles", n, max_wait);
        end else begin
            check_value({name, " fetch count"}, resident.exists(line_addr) ? 0 : 1, fetches);
            check_value({name, " write-back count"}, has_wb ? 1 : 0, write_backs);
            // pmem_write stays up from its first cycle until resp is seen
            check_value({name, " write cycles"}, has_wb ? write_delay + 1 : 0, write_cycles);
            // a dirty victim keeps eviction up for the whole write-back
            check_value({name, " eviction cycles"},
                        has_ev ? (has_wb ? write_delay + 1 : 1) : 0, evict_cycles);
            if (has_ev) resident.delete(ev_addr);
            if (has_wb) resident.delete(wb_addr);
            resident[line_addr] = 1'b1;
            if (is_write) last_write[line_addr] = wseed;
        end
    endtask

    initial begin : main
        int                   fd;
        int                   requests;
        int                   cycles;
        logic [8*128-1:0]     text;
        logic [8*8-1:0]       op_s;
        logic [8*8-1:0]       wb_s;
        logic [8*8-1:0]       ev_s;
        l2_cache_pkg::l2_word addr;
        l2_cache_pkg::l2_word wb_addr;
        l2_cache_pkg::l2_word ev_addr;
        logic [15:0]          wseed;
        logic [15:0]          rseed;

        void'($urandom(32'hd3f5dbd3));
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_address = '0;
        mem_wdata   = '0;
        pmem_resp   = 1'b0;
        pmem_rdata  = '0;
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        mem_delay   = 0;
        write_delay = 0;
        requests    = 0;
        cycles      = 0;
        wb_addr     = '0;
        ev_addr     = '0;

        while (reset !== 1'b0 && cycles < max_wait) begin
            @(posedge clk);
            cycles++;
        end
        if (reset !== 1'b0) begin
            timeouts++;
            $display("timeout, reset was never released");
        end
        repeat (4) begin                                // quiet until the first request
            @(posedge clk);
            check_value("idle outputs", '0, {mem_resp, pmem_read, pmem_write, eviction});
        end

        fd = $fopen("sim/l2_cache_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the trace file sim/l2_cache_trace.txt");
        end else begin
            while (!$feof(fd) && timeouts == 0) begin
                text = '0;
                void'($fgets(text, fd));
                if ($sscanf(text, "%s %h %h %h %s %s", op_s, addr, wseed, rseed, wb_s, ev_s)
                        == 6) begin
                    if (wb_s != "none") void'($sscanf(wb_s, "%h", wb_addr));
                    if (ev_s != "none") void'($sscanf(ev_s, "%h", ev_addr));
                    requests++;
                    run_request(requests, op_s == "W", addr, wseed, rseed,
                                wb_s != "none", wb_addr, ev_s != "none", ev_addr);
                end
            end
            $fclose(fd);
        end
        if (requests == 0) begin
            errors++;
            $display("no requests were read from the trace");
        end

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule : l2_cache_tb

//--- sim/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period = 20;        // 40 ns clock

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    end

endmodule : tb_clock

//--- source/l2_cache.sv
module l2_cache #(
    parameter int set_bits = 3                  // 8 sets
) (
    input  logic                    clk,
    input  logic                    reset,

    // upstream requester
    input  logic                    mem_read,
    input  logic                    mem_write,
    input  l2_cache_pkg::l2_word    mem_address,
    input  l2_cache_pkg::l2_line    mem_wdata,
    output logic                    mem_resp,
    output l2_cache_pkg::l2_line    mem_rdata,

    // physical memory
    output logic                    pmem_read,
    output logic                    pmem_write,
    output l2_cache_pkg::l2_word    pmem_address,
    output l2_cache_pkg::l2_line    pmem_wdata,
    input  logic                    pmem_resp,
    input  l2_cache_pkg::l2_line    pmem_rdata,

    // eviction notice
    output logic                    eviction,
    output l2_cache_pkg::l2_word    evict_address
);

    l2_cache_pkg::l2_way_status status;
    l2_cache_pkg::l2_way_ctl    ctl;
    logic [2:0]                 victim_way;
    l2_cache_pkg::l2_line       way_rdata;
    logic [10-set_bits:0]       victim_tag;

    l2_way_array #(
        .set_bits (set_bits)
    ) u_way_array (
        .clk        (clk),
        .reset      (reset),
        .address    (mem_address),
        .ctl        (ctl),
        .fill_data  (pmem_rdata),
        .write_data (mem_wdata),
        .victim_way (victim_way),
        .status     (status),
        .hit_data   (mem_rdata),
        .way_rdata  (way_rdata),
        .victim_tag (victim_tag)
    );

    l2_plru #(
        .set_bits (set_bits)
    ) u_plru (
        .clk        (clk),
        .reset      (reset),
        .set_index  (mem_address[l2_cache_pkg::offset_bits +: set_bits]),
        .load_lru   (ctl.load_lru),
        .access_way (ctl.way_sel),
        .victim_way (victim_way)
    );

    l2_cache_control #(
        .set_bits (set_bits)
    ) u_control (
        .clk           (clk),
        .reset         (reset),
        .status        (status),
        .victim_way    (victim_way),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_address   (mem_address),
        .victim_tag    (victim_tag),
        .way_rdata     (way_rdata),
        .ctl           (ctl),
        .mem_resp      (mem_resp),
        .pmem_read     (pmem_read),
        .pmem_write    (pmem_write),
        .pmem_resp     (pmem_resp),
        .pmem_address  (pmem_address),
        .pmem_wdata    (pmem_wdata),
        .eviction      (eviction),
        .evict_address (evict_address)
    );

endmodule : l2_cache

//--- source/l2_cache_control.sv
module l2_cache_control #(
    parameter int set_bits = 3
) (
    input  logic                        clk,
    input  logic                        reset,
    input  l2_cache_pkg::l2_way_status  status,
    input  logic [2:0]                  victim_way,
    input  logic                        mem_read,
    input  logic                        mem_write,
    input  l2_cache_pkg::l2_word        mem_address,
    input  logic [10-set_bits:0]        victim_tag,
    input  l2_cache_pkg::l2_line        way_rdata,
    output l2_cache_pkg::l2_way_ctl     ctl,
    output logic                        mem_resp,
    output logic                        pmem_read,
    output logic                        pmem_write,
    input  logic                        pmem_resp,
    output l2_cache_pkg::l2_word        pmem_address,
    output l2_cache_pkg::l2_line        pmem_wdata,
    output logic                        eviction,
    output l2_cache_pkg::l2_word        evict_address
);

    localparam int offset_bits = l2_cache_pkg::offset_bits;

    l2_cache_pkg::l2_state_e    state;
    l2_cache_pkg::l2_state_e    next_state;
    l2_cache_pkg::l2_addr_src_e addr_src;

    logic                 request;
    logic                 hit;
    logic [2:0]           hit_way;
    logic                 victim_valid;
    logic                 victim_dirty;
    l2_cache_pkg::l2_word fill_address;
    l2_cache_pkg::l2_word victim_address;

    assign request      = mem_read | mem_write;
    assign hit          = |status.hit;
    assign victim_valid = status.valid[victim_way];
    assign victim_dirty = status.dirty[victim_way];

    assign fill_address = {mem_address[l2_cache_pkg::addr_bits-1:offset_bits],
                           {offset_bits{1'b0}}};
    assign victim_address = {victim_tag, mem_address[offset_bits +: set_bits],
                             {offset_bits{1'b0}}};
    assign evict_address = victim_address;

    always_comb begin : hit_encode
        hit_way = '0;
        for (int w = 0; w < l2_cache_pkg::num_ways; w++) begin
            if (status.hit[w]) begin
                hit_way = 3'(w);
            end
        end
    end

    // ########################################
    // next state

    always_comb begin : next_state_logic
        next_state = state;
        case (state)
            l2_cache_pkg::process_request: begin
                if (request) begin
                    if (hit) next_state = l2_cache_pkg::respond_wait;
                    else if (victim_dirty) next_state = l2_cache_pkg::write_back;
                    else if (victim_valid) next_state = l2_cache_pkg::evict_line;
                    else next_state = l2_cache_pkg::fetch_line;
                end
            end
            l2_cache_pkg::write_back: begin
                if (pmem_resp) next_state = l2_cache_pkg::fetch_line;
            end
            l2_cache_pkg::evict_line: next_state = l2_cache_pkg::fetch_line;
            l2_cache_pkg::fetch_line: begin
                if (pmem_resp) next_state = l2_cache_pkg::process_request;
            end
            default: next_state = l2_cache_pkg::process_request;    // respond_wait
        endcase
    end

    // ########################################
    // state outputs

    always_comb begin : state_outputs
        ctl         = '0;
        ctl.way_sel = hit ? hit_way : victim_way;
        mem_resp    = 1'b0;
        pmem_read   = 1'b0;
        pmem_write  = 1'b0;
        eviction    = 1'b0;
        addr_src    = l2_cache_pkg::addr_request;
        case (state)
            l2_cache_pkg::process_request: begin
                if (request && hit) begin
                    mem_resp     = 1'b1;
                    ctl.load_lru = 1'b1;
                    if (mem_write) begin
                        ctl.load_line  = 1'b1;
                        ctl.load_dirty = 1'b1;
                        ctl.dirty_in   = 1'b1;
                    end
                end
                if (next_state == l2_cache_pkg::write_back) begin
                    addr_src = l2_cache_pkg::addr_victim;       // set up ahead of write_back
                end
            end
            l2_cache_pkg::write_back: begin
                eviction   = 1'b1;
                pmem_write = 1'b1;
                if (!pmem_resp) begin
                    addr_src = l2_cache_pkg::addr_victim;       // switches to fill on resp
                end
            end
            l2_cache_pkg::evict_line: eviction = 1'b1;
            l2_cache_pkg::fetch_line: begin
                pmem_read = 1'b1;
                if (pmem_resp) begin                            // fill lands clean
                    ctl.load_line  = 1'b1;
                    ctl.load_valid = 1'b1;
                    ctl.valid_in   = 1'b1;
                    ctl.load_dirty = 1'b1;
                    ctl.dirty_in   = 1'b0;
                end
            end
            default: ;
        endcase
    end

    // ########################################
    // registers

    always_ff @(posedge clk) begin : state_reg
        if (reset) begin
            state <= l2_cache_pkg::process_request;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin : pmem_regs
        if (addr_src == l2_cache_pkg::addr_victim) begin
            pmem_address <= victim_address;
            pmem_wdata   <= way_rdata;
        end else begin
            pmem_address <= fill_address;
        end
    end

    upstream_one_op: assert property (@(posedge clk) disable iff (reset)
        !(mem_read && mem_write));

    pmem_one_op: assert property (@(posedge clk) disable iff (reset)
        !(pmem_read && pmem_write));

endmodule : l2_cache_control

//--- source/l2_plru.sv
module l2_plru #(
    parameter int set_bits = 3
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [set_bits-1:0] set_index,
    input  logic                load_lru,
    input  logic [2:0]          access_way,
    output logic [2:0]          victim_way
);

    localparam int num_sets = 1 << set_bits;

    logic [6:0] tree [num_sets];
    logic [6:0] cur;
    logic [6:0] next_bits;

    assign cur = tree[set_index];

    // ########################################
    // walk the tree toward the victim

    always_comb begin : victim_walk
        victim_way[2] = cur[0];                             // half
        victim_way[1] = cur[1 + victim_way[2]];             // pair in that half
        victim_way[0] = cur[3 + victim_way[2:1]];           // way in that pair
    end

    // ########################################
    // point every bit on the path away from the accessed way

    always_comb begin : path_update
        next_bits = cur;
        next_bits[0] = ~access_way[2];
        next_bits[1 + access_way[2]] = ~access_way[1];
        next_bits[3 + access_way[2:1]] = ~access_way[0];
    end

    always_ff @(posedge clk) begin : tree_store
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                tree[s] <= '0;
            end
        end else if (load_lru) begin
            tree[set_index] <= next_bits;
        end
    end

endmodule : l2_plru

//--- source/l2_way_array.sv
module l2_way_array #(
    parameter int set_bits = 3
) (
    input  logic                        clk,
    input  logic                        reset,
    input  l2_cache_pkg::l2_word        address,
    input  l2_cache_pkg::l2_way_ctl     ctl,
    input  l2_cache_pkg::l2_line        fill_data,
    input  l2_cache_pkg::l2_line        write_data,
    input  logic [2:0]                  victim_way,
    output l2_cache_pkg::l2_way_status  status,
    output l2_cache_pkg::l2_line        hit_data,
    output l2_cache_pkg::l2_line        way_rdata,
    output logic [10-set_bits:0]        victim_tag
);

    localparam int num_sets = 1 << set_bits;
    localparam int tag_bits = l2_cache_pkg::addr_bits - l2_cache_pkg::offset_bits - set_bits;
    localparam int num_ways = l2_cache_pkg::num_ways;

    logic [tag_bits-1:0]  tags [num_ways][num_sets];
    l2_cache_pkg::l2_line data [num_ways][num_sets];
    logic [num_sets-1:0][num_ways-1:0] valid_q;
    logic [num_sets-1:0][num_ways-1:0] dirty_q;

    logic [set_bits-1:0]  set_index;
    logic [tag_bits-1:0]  tag;
    l2_cache_pkg::l2_line line_in;

    assign set_index = address[l2_cache_pkg::offset_bits +: set_bits];
    assign tag       = address[l2_cache_pkg::addr_bits-1 -: tag_bits];
    assign line_in   = (ctl.load_valid && ctl.valid_in) ? fill_data : write_data;

    // ########################################
    // lookup

    always_comb begin : lookup
        hit_data = '0;
        for (int w = 0; w < num_ways; w++) begin
            status.valid[w] = valid_q[set_index][w];
            status.dirty[w] = dirty_q[set_index][w];
            status.hit[w]   = valid_q[set_index][w] && (tags[w][set_index] == tag);
            if (status.hit[w]) begin
                hit_data = data[w][set_index];
            end
        end
    end

    assign way_rdata  = data[victim_way][set_index];
    assign victim_tag = tags[victim_way][set_index];

    // ########################################
    // update

    always_ff @(posedge clk) begin : line_write
        if (ctl.load_line) begin
            data[ctl.way_sel][set_index] <= line_in;
            tags[ctl.way_sel][set_index] <= tag;        // unchanged on a write hit
        end
    end

    always_ff @(posedge clk) begin : state_bits
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (ctl.load_valid) begin
                valid_q[set_index][ctl.way_sel] <= ctl.valid_in;
            end
            if (ctl.load_dirty) begin
                dirty_q[set_index][ctl.way_sel] <= ctl.dirty_in;
            end
        end
    end

    // a tag lives in one way of a set, so a fill never duplicates it
    single_hit: assert property (@(posedge clk) disable iff (reset) $onehot0(status.hit));

endmodule : l2_way_array

//--- source/l2_cache_pkg.sv
package l2_cache_pkg;

    // ########################################
    // address and line layout

    localparam int addr_bits   = 16;
    localparam int offset_bits = 5;     // 32 byte lines
    localparam int num_ways    = 8;     // fixed by the 7 bit tree lru

    typedef logic [addr_bits-1:0] l2_word;
    typedef logic [255:0] l2_line;

    // ########################################
    // way status and control

    typedef struct packed {
        logic [num_ways-1:0] hit;
        logic [num_ways-1:0] valid;
        logic [num_ways-1:0] dirty;
    } l2_way_status;

    typedef struct packed {
        logic [2:0] way_sel;            // hit way or victim way
        logic       load_line;          // data and tag write
        logic       load_valid;
        logic       valid_in;           // also picks fill data over write data
        logic       load_dirty;
        logic       dirty_in;
        logic       load_lru;
    } l2_way_ctl;

    // ########################################
    // controller

    typedef enum logic [2:0] {
        process_request,
        write_back,
        evict_line,
        fetch_line,
        respond_wait
    } l2_state_e;

    typedef enum logic {
        addr_request,                   // line address of the request, for fills
        addr_victim
    } l2_addr_src_e;

endpackage : l2_cache_pkg
